// ==== decodeCore.f ====
+incdir+.
isaPkg.sv
pipePkg.sv
instrDecoder.sv
execUnit.sv
resultStage.sv
decodeCore.sv
decodeCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the pipeline testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module decodeCoreTb \
	-f decodeCore.f -o simDecodeCore

output="$(./obj_dir/simDecodeCore)"
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1

// ==== tbChecks.svh ====
// Compare tasks, error counters and the closing report for the pipeline testbench
// Included into the body of the testbench module

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

	// ============================================================
	// Error counters
	// ============================================================
	// Wrong values seen on the result stream or on a status output
	int valueErrors = 0;
	// Lost, extra or late results and broken flow control
	int flowErrors = 0;

	// Register number of a result
	task automatic checkReg(regNum_t got, regNum_t exp, string what);
		if (got !== exp) begin
			valueErrors++;
			$display("FAILED at %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
		end
	endtask

	// Data word of a result
	task automatic checkData(word_t got, word_t exp, string what);
		if (got !== exp) begin
			valueErrors++;
			$display("FAILED at %0t: %s is %08h, expected %08h", $time, what, got, exp);
		end
	endtask

	// Single status bit such as a valid or ready
	task automatic checkBit(logic got, logic exp, string what);
		if (got !== exp) begin
			valueErrors++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// One closing line with both counts
	task automatic printSummary();
		$display("Checks done: %0d value errors, %0d flow errors, %0d instructions sent",
			valueErrors, flowErrors, sentCount);
	endtask

`endif

// ==== decodeCoreTb.sv ====
// Testbench for the three-stage integer pipeline
// Directed tests drive the instruction stream, a reference register
// model predicts every result and a monitor checks the result stream

`timescale 1ns/1ps

module decodeCoreTb import isaPkg::*; ();

	localparam int DataWidth = 32;
	localparam int ClkPeriod = 20;
	localparam int unsigned Seed = 32'hf64416f6;

	typedef logic [DataWidth-1:0] word_t;

	// Expected result of one instruction, kept in the order of issue
	typedef struct packed {
		regNum_t dst;
		word_t value;
	} expect_t;

	logic clk;
	logic rst;
	logic instrValid;
	instr_t instr;
	logic instrReady;
	logic resValid;
	regNum_t resReg;
	word_t resData;
	logic resReady;

	// Consumer stalls at random while this is set
	logic randomReady;
	int sentCount;
	word_t refRegs [NumRegs];
	expect_t expQ[$];

	`include "tbChecks.svh"

	decodeCore #(.DataWidth(DataWidth)) u_dut (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.instrReady(instrReady),
		.resValid(resValid),
		.resReg(resReg),
		.resData(resData),
		.resReady(resReady)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(ClkPeriod / 2) clk = ~clk;
		end
	end

	// ============================================================
	// Reference model and instruction encoding
	// ============================================================
	function automatic instr_t encodeR2(func_t fn, regNum_t rt, regNum_t ra, regNum_t rb);
		return {OP_R2, rt, ra, rb, 5'b00000, fn};
	endfunction

	function automatic instr_t encodeImm(opcode_t op, regNum_t rt, regNum_t ra,
		logic [15:0] imm);
		return {op, rt, ra, imm};
	endfunction

	// Applies one accepted instruction to the model registers
	function automatic void applyModel(instr_t ins);
		opcode_t op;
		func_t fn;
		regNum_t rt;
		word_t a;
		word_t b;
		word_t sImm;
		word_t zImm;
		word_t res;
		logic isNop;
		expect_t e;
		op = ins[31:26];
		fn = ins[5:0];
		rt = ins[25:21];
		a = refRegs[ins[20:16]];
		b = refRegs[ins[15:11]];
		sImm = {{16{ins[15]}}, ins[15:0]};
		zImm = {16'h0000, ins[15:0]};
		isNop = 1'b0;
		res = '0;
		case (op)
			OP_R2: begin
				case (fn)
					FN_ADD: res = a + b;
					FN_SUB: res = a - b;
					FN_AND: res = a & b;
					FN_OR: res = a | b;
					FN_XOR: res = a ^ b;
					FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: isNop = 1'b1;
				endcase
			end
			OP_ADDI: res = a + sImm;
			OP_ANDI: res = a & zImm;
			OP_ORI: res = a | zImm;
			OP_LDI: res = sImm;
			default: isNop = 1'b1;
		endcase
		// Nops and unknown encodings leave no trace at all
		if (!isNop) begin
			e.dst = rt;
			e.value = res;
			expQ.push_back(e);
			// A write to r0 still shows as a result but changes nothing
			if (rt != '0) begin
				refRegs[rt] = res;
			end
		end
	endfunction

	// ============================================================
	// Stream drivers
	// ============================================================
	// Offers one instruction and returns once the pipe has taken it
	task automatic sendInstr(instr_t ins);
		logic taken;
		instr = ins;
		instrValid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = instrReady;
			@(posedge clk);
			#1;
		end
		instrValid = 1'b0;
		applyModel(ins);
		sentCount++;
	endtask

	task automatic idleCycles(int n);
		instrValid = 1'b0;
		repeat (n) @(posedge clk);
		#1;
	endtask

	// Waits for every expected result and then a few more cycles for strays
	task automatic drainResults();
		int waited;
		instrValid = 1'b0;
		waited = 0;
		while (expQ.size() != 0 && waited < 400) begin
			@(posedge clk);
			waited++;
		end
		repeat (4) @(posedge clk);
		#1;
		if (expQ.size() != 0) begin
			flowErrors++;
			$display("Error: %0d expected results never left the pipe", expQ.size());
			expQ.delete();
		end
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic testResetState();
		@(negedge clk);
		checkBit(resValid, 1'b0, "resValid after reset");
		checkBit(instrReady, 1'b1, "instrReady after reset");
		@(posedge clk);
		#1;
	endtask

	// Every function and immediate form on operands from the register file
	task automatic testAluOps();
		sendInstr(encodeImm(OP_LDI, 5'd1, 5'd0, 16'hFFFB));
		sendInstr(encodeImm(OP_LDI, 5'd2, 5'd0, 16'h0007));
		sendInstr(encodeImm(OP_LDI, 5'd3, 5'd0, 16'h8000));
		sendInstr(encodeR2(FN_ADD, 5'd4, 5'd1, 5'd2));
		sendInstr(encodeR2(FN_SUB, 5'd5, 5'd1, 5'd2));
		sendInstr(encodeR2(FN_AND, 5'd6, 5'd1, 5'd2));
		sendInstr(encodeR2(FN_OR, 5'd7, 5'd1, 5'd2));
		sendInstr(encodeR2(FN_XOR, 5'd8, 5'd1, 5'd2));
		// Negative against positive in both orders
		sendInstr(encodeR2(FN_SLT, 5'd9, 5'd1, 5'd2));
		sendInstr(encodeR2(FN_SLT, 5'd10, 5'd2, 5'd1));
		sendInstr(encodeR2(FN_SLT, 5'd11, 5'd3, 5'd1));
		sendInstr(encodeImm(OP_ADDI, 5'd12, 5'd1, 16'hFFFF));
		sendInstr(encodeImm(OP_ANDI, 5'd13, 5'd1, 16'hFF0F));
		sendInstr(encodeImm(OP_ORI, 5'd14, 5'd2, 16'h8000));
		sendInstr(encodeImm(OP_ADDI, 5'd15, 5'd3, 16'h7FFF));
		drainResults();
	endtask

	// Each step reads the previous target and the one before it
	task automatic testDependentChain();
		int i;
		func_t fn;
		sendInstr(encodeImm(OP_LDI, 5'd16, 5'd0, 16'd3));
		sendInstr(encodeImm(OP_LDI, 5'd17, 5'd0, 16'd5));
		for (i = 18; i < 28; i++) begin
			fn = (i % 3 == 0) ? FN_SUB : ((i % 3 == 1) ? FN_ADD : FN_XOR);
			// Odd steps swap the sources so the forwarded value arrives on port B
			if (i % 2 == 0) begin
				sendInstr(encodeR2(fn, regNum_t'(i), regNum_t'(i - 1), regNum_t'(i - 2)));
			end else begin
				sendInstr(encodeR2(fn, regNum_t'(i), regNum_t'(i - 2), regNum_t'(i - 1)));
			end
		end
		sendInstr(encodeImm(OP_ADDI, 5'd28, 5'd27, 16'h0001));
		drainResults();
	endtask

	task automatic testZeroAndNops();
		sendInstr(encodeImm(OP_LDI, 5'd2, 5'd0, 16'h0040));
		// The r0 write is a visible result but the next read must still see zero
		sendInstr(encodeImm(OP_ADDI, 5'd0, 5'd2, 16'h0064));
		sendInstr(encodeR2(FN_ADD, 5'd20, 5'd0, 5'd2));
		sendInstr({OP_NOP, 26'h3FFFFFF});
		sendInstr({6'h3F, 26'h0421234});
		sendInstr(encodeR2(6'h3F, 5'd5, 5'd1, 5'd2));
		idleCycles(5);
		sendInstr(encodeImm(OP_ORI, 5'd21, 5'd0, 16'h0005));
		sendInstr(encodeR2(FN_SUB, 5'd0, 5'd2, 5'd21));
		sendInstr(encodeR2(FN_OR, 5'd22, 5'd0, 5'd0));
		drainResults();
	endtask

	// Random instructions over r0 to r7 against a randomly stalling consumer
	task automatic testBackPressure();
		int n;
		int sel;
		regNum_t rt;
		regNum_t ra;
		regNum_t rb;
		logic [15:0] imm;
		randomReady = 1'b1;
		for (n = 1; n < 8; n++) begin
			sendInstr(encodeImm(OP_LDI, regNum_t'(n), 5'd0, 16'($urandom)));
		end
		for (n = 0; n < 80; n++) begin
			sel = int'($urandom % 10);
			rt = regNum_t'($urandom % 8);
			ra = regNum_t'($urandom % 8);
			rb = regNum_t'($urandom % 8);
			imm = 16'($urandom);
			case (sel)
				0: sendInstr(encodeR2(FN_ADD, rt, ra, rb));
				1: sendInstr(encodeR2(FN_SUB, rt, ra, rb));
				2: sendInstr(encodeR2(FN_AND, rt, ra, rb));
				3: sendInstr(encodeR2(FN_OR, rt, ra, rb));
				4: sendInstr(encodeR2(FN_XOR, rt, ra, rb));
				5: sendInstr(encodeR2(FN_SLT, rt, ra, rb));
				6: sendInstr(encodeImm(OP_ADDI, rt, ra, imm));
				7: sendInstr(encodeImm(OP_ANDI, rt, ra, imm));
				8: sendInstr(encodeImm(OP_ORI, rt, ra, imm));
				default: sendInstr(encodeImm(OP_LDI, rt, 5'd0, imm));
			endcase
		end
		drainResults();
		randomReady = 1'b0;
	endtask

	// ============================================================
	// Consumer, monitor and watchdog
	// ============================================================
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (randomReady) begin
				resReady = 1'($urandom % 2);
			end else begin
				resReady = 1'b1;
			end
		end
	end

	// Sampled mid-cycle where every input and output is settled
	always @(negedge clk) begin
		expect_t e;
		if (!rst) begin
			// The input side may only stall while a result is held
			checkBit(instrReady, !resValid || resReady, "instrReady");
			if (resValid && resReady) begin
				if (expQ.size() == 0) begin
					flowErrors++;
					$display("Error: result for r%0d came out with no instruction behind it",
						resReg);
				end else begin
					e = expQ.pop_front();
					checkReg(resReg, e.dst, "resReg");
					checkData(resData, e.value, "resData");
				end
			end
		end
	end

	// Budget grows with every instruction sent
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < 1000 + 40 * sentCount) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycles);
		printSummary();
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int i;
		void'($urandom(Seed));
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		resReady = 1'b1;
		randomReady = 1'b0;
		sentCount = 0;
		for (i = 0; i < NumRegs; i++) begin
			refRegs[i] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		testResetState();
		testAluOps();
		testDependentChain();
		testZeroAndNops();
		testBackPressure();
		printSummary();
		if (valueErrors == 0 && flowErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== decodeCore.sv ====
// Top level of the three-stage integer pipeline
// Instructions come in on a valid/ready stream, results leave on
// another, and one advance signal stalls every stage together

`timescale 1ns/1ps

module decodeCore import isaPkg::*, pipePkg::*; #(
	parameter int DataWidth = BusDataWidth
) (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input instr_t instr,
	output logic instrReady,
	output logic resValid,
	output regNum_t resReg,
	output logic [DataWidth-1:0] resData,
	input logic resReady
);

	logic advance;
	decodeBus_t db;
	execResult_t exRes;
	regNum_t rdAddrA;
	regNum_t rdAddrB;
	logic [DataWidth-1:0] rdDataA;
	logic [DataWidth-1:0] rdDataB;

	// An instruction is taken whenever the pipe moves
	assign instrReady = advance;

	// ============================================================
	// Stages
	// ============================================================
	instrDecoder #(.DataWidth(DataWidth)) u_decoder (
		.clk(clk),
		.rst(rst),
		.en(advance),
		.instr(instr),
		.instrValid(instrValid),
		.dbo(db)
	);

	execUnit #(.DataWidth(DataWidth)) u_exec (
		.clk(clk),
		.rst(rst),
		.en(advance),
		.db(db),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.exRes(exRes)
	);

	resultStage #(.DataWidth(DataWidth)) u_result (
		.clk(clk),
		.rst(rst),
		.exRes(exRes),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.resValid(resValid),
		.resReg(resReg),
		.resData(resData),
		.resReady(resReady),
		.advance(advance)
	);

endmodule

// ==== resultStage.sv ====
// Result stage
// Holds the register file, writes results into it, presents each
// result on the output stream and drives the pipeline advance

`timescale 1ns/1ps

module resultStage import isaPkg::*, pipePkg::*; #(
	parameter int DataWidth = BusDataWidth
) (
	input logic clk,
	input logic rst,
	input execResult_t exRes,
	input regNum_t rdAddrA,
	input regNum_t rdAddrB,
	output logic [DataWidth-1:0] rdDataA,
	output logic [DataWidth-1:0] rdDataB,
	output logic resValid,
	output regNum_t resReg,
	output logic [DataWidth-1:0] resData,
	input logic resReady,
	output logic advance
);

	logic [DataWidth-1:0] regFile [NumRegs];
	logic wrEn;

	// ============================================================
	// Flow control
	// ============================================================
	// The pipe moves unless a result is held waiting for the consumer
	assign advance = !resValid || resReady;

	// Writes happen on the same edge that loads the output register
	assign wrEn = advance && exRes.valid && exRes.Rtv;

	// ============================================================
	// Register file
	// ============================================================
	always_ff @(posedge clk) begin
		if (wrEn) begin
			regFile[exRes.Rt] <= DataWidth'(exRes.data);
		end
	end

	// Combinational reads, r0 always returns zero
	assign rdDataA = (rdAddrA == '0) ? '0 : regFile[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regFile[rdAddrB];

	// Output register, the payload carries no reset
	always_ff @(posedge clk) begin
		if (rst) begin
			resValid <= 1'b0;
		end else if (advance) begin
			resValid <= exRes.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			resReg <= exRes.Rt;
			resData <= DataWidth'(exRes.data);
		end
	end

	// A held result stays offered and unchanged until it is taken
	assert property (@(posedge clk) disable iff (rst)
		resValid && !resReady |=> resValid && $stable(resReg) && $stable(resData))
		else $error("resultStage: result changed while stalled");

endmodule

// ==== execUnit.sv ====
// Execute stage
// Picks the operands from zero, the forwarded previous result, the
// register file or the immediate, and registers the ALU result

`timescale 1ns/1ps

module execUnit import isaPkg::*, pipePkg::*; #(
	parameter int DataWidth = BusDataWidth
) (
	input logic clk,
	input logic rst,
	input logic en,
	input decodeBus_t db,
	output regNum_t rdAddrA,
	output regNum_t rdAddrB,
	input logic [DataWidth-1:0] rdDataA,
	input logic [DataWidth-1:0] rdDataB,
	output execResult_t exRes
);

	logic fwdA;
	logic fwdB;
	logic [DataWidth-1:0] fwdData;
	logic [DataWidth-1:0] opA;
	logic [DataWidth-1:0] regB;
	logic [DataWidth-1:0] opB;
	logic [DataWidth-1:0] aluRes;

	// Register file read addresses come straight from the decode bus
	assign rdAddrA = db.Ra;
	assign rdAddrB = db.Rb;

	// ============================================================
	// Operand selection
	// ============================================================
	// The register file already holds every older result except the one
	// sitting in exRes, so only that one is forwarded
	assign fwdData = DataWidth'(exRes.data);
	assign fwdA = exRes.valid && exRes.Rtv && (exRes.Rt == db.Ra);
	assign fwdB = exRes.valid && exRes.Rtv && (exRes.Rt == db.Rb);

	always_comb begin
		if (db.Raz) begin
			opA = '0;
		end else if (fwdA) begin
			opA = fwdData;
		end else begin
			opA = rdDataA;
		end
	end

	always_comb begin
		if (db.Rbz) begin
			regB = '0;
		end else if (fwdB) begin
			regB = fwdData;
		end else begin
			regB = rdDataB;
		end
	end

	// Immediate forms replace the second register operand
	assign opB = db.hasImm ? DataWidth'(db.imm) : regB;

	// ============================================================
	// ALU
	// ============================================================
	always_comb begin
		case (db.aluOp)
			ALU_ADD: aluRes = opA + opB;
			ALU_SUB: aluRes = opA - opB;
			ALU_AND: aluRes = opA & opB;
			ALU_OR: aluRes = opA | opB;
			ALU_XOR: aluRes = opA ^ opB;
			// Signed compare, result is 1 or 0
			ALU_SLT: aluRes = {{(DataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
			ALU_PASSB: aluRes = opB;
			default: aluRes = '0;
		endcase
	end

	// Result register, only the control bits are cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			exRes.valid <= 1'b0;
			exRes.Rtv <= 1'b0;
		end else if (en) begin
			exRes.valid <= !db.nop;
			exRes.Rtv <= db.Rtv;
		end
		if (!rst && en) begin
			exRes.Rt <= db.Rt;
			exRes.data <= data_t'(aluRes);
		end
	end

	// The decoder must keep r0 writes out of the write path
	assert property (@(posedge clk) disable iff (rst)
		exRes.valid && exRes.Rtv |-> exRes.Rt != '0)
		else $error("execUnit: register write to r0 in exRes");

endmodule

// ==== instrDecoder.sv ====
// Instruction decoder stage
// Splits an instruction into register fields, zero flags, an extended
// immediate and an ALU operation, then registers the decode bus

`timescale 1ns/1ps

module instrDecoder import isaPkg::*, pipePkg::*; #(
	parameter int DataWidth = BusDataWidth
) (
	input logic clk,
	input logic rst,
	input logic en,
	input instr_t instr,
	input logic instrValid,
	output decodeBus_t dbo
);

	// Bus loaded on reset and for bubbles
	localparam decodeBus_t NopBus = '{
		Ra: '0,
		Rb: '0,
		Rt: '0,
		Raz: 1'b1,
		Rbz: 1'b1,
		Rtv: 1'b0,
		hasImm: 1'b0,
		imm: '0,
		aluOp: ALU_ADD,
		nop: 1'b1
	};

	opcode_t opcode;
	func_t func;
	regNum_t ra;
	regNum_t rb;
	regNum_t rt;
	imm_t immField;
	logic signExt;
	logic [DataWidth-1:0] immSext;
	logic [DataWidth-1:0] immZext;
	decodeBus_t db;

	// ============================================================
	// Field extraction
	// ============================================================
	assign opcode = opcodeOf(instr);
	assign func = funcOf(instr);
	assign ra = raOf(instr);
	assign rb = rbOf(instr);
	assign rt = rtOf(instr);
	assign immField = immOf(instr);

	// ADDI and LDI take the signed form, ANDI and ORI the unsigned one
	assign immSext = {{(DataWidth-ImmWidth){immField[ImmWidth-1]}}, immField};
	assign immZext = {{(DataWidth-ImmWidth){1'b0}}, immField};

	always_comb begin
		db = NopBus;
		db.Ra = ra;
		db.Rb = rb;
		db.Rt = rt;
		db.nop = 1'b0;
		signExt = 1'b0;
		case (opcode)
			OP_R2: begin
				case (func)
					FN_ADD: db.aluOp = ALU_ADD;
					FN_SUB: db.aluOp = ALU_SUB;
					FN_AND: db.aluOp = ALU_AND;
					FN_OR: db.aluOp = ALU_OR;
					FN_XOR: db.aluOp = ALU_XOR;
					FN_SLT: db.aluOp = ALU_SLT;
					// Unknown function code is dropped as a nop
					default: db.nop = 1'b1;
				endcase
			end
			OP_ADDI: begin
				db.hasImm = 1'b1;
				db.aluOp = ALU_ADD;
				signExt = 1'b1;
			end
			OP_ANDI: begin
				db.hasImm = 1'b1;
				db.aluOp = ALU_AND;
			end
			OP_ORI: begin
				db.hasImm = 1'b1;
				db.aluOp = ALU_OR;
			end
			OP_LDI: begin
				db.hasImm = 1'b1;
				db.aluOp = ALU_PASSB;
				signExt = 1'b1;
			end
			OP_NOP: db.nop = 1'b1;
			default: db.nop = 1'b1;
		endcase
		db.imm = data_t'(signExt ? immSext : immZext);
		// LDI never reads Ra, and immediate forms never read Rb
		db.Raz = (ra == '0) || (opcode == OP_LDI);
		db.Rbz = (rb == '0) || db.hasImm;
		// No write for r0, and none at all for a nop
		db.Rtv = !db.nop && (rt != '0);
	end

	// ============================================================
	// Decode register, a missing instruction becomes a bubble
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			dbo <= NopBus;
		end else if (en) begin
			dbo <= instrValid ? db : NopBus;
		end
	end

	// A nop must never reach execute with a pending register write
	assert property (@(posedge clk) disable iff (rst) dbo.nop |-> !dbo.Rtv)
		else $error("instrDecoder: nop on the decode bus has Rtv set");

endmodule

// ==== pipePkg.sv ====
// Pipeline types shared between the decode, execute and result stages
// The ALU operation set, the decode bus and the execute result

package pipePkg;

	import isaPkg::*;

	// Width of the data fields carried on the stage buses
	// The stage modules take DataWidth with this as the default
	localparam int BusDataWidth = 32;

	typedef logic [BusDataWidth-1:0] data_t;

	// ALU operations, PASSB forwards operand B untouched for LDI
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASSB
	} aluOp_t;

	// ============================================================
	// Decode bus, registered at the decode-to-execute boundary
	// ============================================================
	typedef struct packed {
		regNum_t Ra;
		regNum_t Rb;
		regNum_t Rt;
		// Source reads as zero, either r0 or not used by the opcode
		logic Raz;
		logic Rbz;
		// Register write due, never set for r0 or a nop
		logic Rtv;
		logic hasImm;
		// Immediate already extended to the data width
		data_t imm;
		aluOp_t aluOp;
		logic nop;
	} decodeBus_t;

	// Execute result, registered at the execute-to-result boundary
	typedef struct packed {
		logic valid;
		regNum_t Rt;
		logic Rtv;
		data_t data;
	} execResult_t;

endpackage

// ==== isaPkg.sv ====
// Instruction set definitions for the small integer pipeline
// Field widths, opcode and function code values, register numbers
// and helpers that pull the fields out of an instruction word

package isaPkg;

	// ============================================================
	// Field widths
	// ============================================================
	localparam int InstrWidth = 32;
	localparam int OpcodeWidth = 6;
	localparam int RegNumWidth = 5;
	localparam int FuncWidth = 6;
	localparam int ImmWidth = 16;
	// Architectural register count, r0 is hardwired to zero
	localparam int NumRegs = 32;

	typedef logic [InstrWidth-1:0] instr_t;
	typedef logic [OpcodeWidth-1:0] opcode_t;
	typedef logic [RegNumWidth-1:0] regNum_t;
	typedef logic [FuncWidth-1:0] func_t;
	typedef logic [ImmWidth-1:0] imm_t;

	// ============================================================
	// Opcodes, anything not listed here decodes as a nop
	// ============================================================
	localparam opcode_t OP_NOP = 6'h00;
	localparam opcode_t OP_R2 = 6'h02;
	localparam opcode_t OP_ADDI = 6'h04;
	localparam opcode_t OP_ANDI = 6'h08;
	localparam opcode_t OP_ORI = 6'h09;
	localparam opcode_t OP_LDI = 6'h0D;

	// Function codes of the register-register group
	localparam func_t FN_ADD = 6'h04;
	localparam func_t FN_SUB = 6'h05;
	localparam func_t FN_AND = 6'h08;
	localparam func_t FN_OR = 6'h09;
	localparam func_t FN_XOR = 6'h0A;
	localparam func_t FN_SLT = 6'h0C;

	// Field extraction
	// Layout is opcode[31:26] Rt[25:21] Ra[20:16] Rb[15:11] func[5:0]
	// Immediate forms carry imm[15:0] in place of Rb and func
	function automatic opcode_t opcodeOf(instr_t i);
		return i[31:26];
	endfunction

	function automatic regNum_t rtOf(instr_t i);
		return i[25:21];
	endfunction

	function automatic regNum_t raOf(instr_t i);
		return i[20:16];
	endfunction

	function automatic regNum_t rbOf(instr_t i);
		return i[15:11];
	endfunction

	function automatic func_t funcOf(instr_t i);
		return i[5:0];
	endfunction

	function automatic imm_t immOf(instr_t i);
		return i[15:0];
	endfunction

endpackage
